// ==== rtl/fetch_pkg.sv ====
package fetch_pkg;

    // fetch requests allowed in flight between the first stage and this one
    localparam int FETCH_DEPTH = 3;
    // wide enough to hold FETCH_DEPTH itself
    localparam int CREDIT_W = $clog2(FETCH_DEPTH + 1);

    // andi r0, r0, 0
    localparam logic [31:0] INST_NOP = 32'h0340_0000;

    // one icache response, two instructions
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] pc_next;
        logic [31:0] inst0;
        logic [31:0] inst1;
        logic [31:0] badv;
        logic [6:0]  exception;
        logic [1:0]  excp_flag;
        logic [31:0] cookie;
    } fetch_bundle_t;

    // predecoder flags, bit n belongs to slot n
    typedef struct packed {
        logic [1:0] ibar;
        logic [1:0] csr;
        logic [1:0] tlb;
        logic [1:0] priv;
    } serial_flags_t;

    // completion reports from execute and the memory side
    typedef struct packed {
        logic ibar_from_ex;
        logic csr_from_ex;
        logic tlb_from_ex;
        logic csr_done;
        logic tlb_done;
        logic icache_idle;
        logic dcache_idle;
    } serial_ack_t;

    // serialization states
    typedef enum logic [2:0] {
        st_idle            = 3'b000,
        st_wait_ex_ibar    = 3'b001,
        st_wait_ex_csr     = 3'b010,
        st_wait_cache_idle = 3'b011,
        st_wait_csr_ok     = 3'b100,
        st_wait_tlb_ok     = 3'b101,
        st_wait_ex_tlb     = 3'b111
    } serial_state_t;

endpackage

// ==== rtl/serial_fsm.sv ====
`timescale 1ns/1ps

module serial_fsm import fetch_pkg::*; (
    input  logic          clk,
    input  logic          rstn,
    input  logic          flush,
    input  logic          rsp_take,
    input  serial_flags_t rsp_flags,
    input  logic [31:0]   rsp_pc,
    input  logic [31:0]   rsp_pc_next,
    input  serial_ack_t   ack,
    output logic          fsm_idle,
    output logic          squash,
    output logic          redirect_valid,
    output logic [31:0]   redirect_pc
);

    serial_state_t state;
    serial_state_t state_next;
    logic          serial_hit;
    logic          cache_idle;
    logic [31:0]   restart_pc;

    // any serializing instruction in the taken bundle
    assign serial_hit = rsp_take &&
                        ((|rsp_flags.ibar) || (|rsp_flags.csr) || (|rsp_flags.tlb));
    assign cache_idle = ack.icache_idle && ack.dcache_idle;

    // restart right after the slot holding the instruction
    always_comb begin
        if (rsp_flags.priv[0]) begin
            restart_pc = rsp_pc + 32'd4;
        end else if (rsp_flags.priv[1]) begin
            restart_pc = rsp_pc + 32'd8;
        end else begin
            restart_pc = rsp_pc_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            st_idle: begin
                if (serial_hit) begin
                    // ibar wins over csr, csr over tlb
                    if (|rsp_flags.ibar) begin
                        state_next = st_wait_ex_ibar;
                    end else if (|rsp_flags.csr) begin
                        state_next = st_wait_ex_csr;
                    end else begin
                        state_next = st_wait_ex_tlb;
                    end
                end
            end
            st_wait_ex_ibar: begin
                if (ack.ibar_from_ex) begin
                    state_next = st_wait_cache_idle;
                end
            end
            st_wait_ex_csr: begin
                if (ack.csr_from_ex) begin
                    state_next = st_wait_csr_ok;
                end
            end
            st_wait_ex_tlb: begin
                if (ack.tlb_from_ex) begin
                    state_next = st_wait_tlb_ok;
                end
            end
            st_wait_cache_idle: begin
                if (cache_idle) begin
                    state_next = st_idle;
                end
            end
            st_wait_csr_ok: begin
                if (ack.csr_done) begin
                    state_next = st_idle;
                end
            end
            st_wait_tlb_ok: begin
                if (ack.tlb_done) begin
                    state_next = st_idle;
                end
            end
            default: begin
                state_next = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn || flush) begin
            state <= st_idle;
        end else begin
            state <= state_next;
        end
    end

    // captured once per serializing bundle
    always_ff @(posedge clk) begin
        if (state == st_idle && serial_hit) begin
            redirect_pc <= restart_pc;
        end
    end

    assign fsm_idle       = (state == st_idle);
    assign redirect_valid = !fsm_idle;
    // younger fetches are dropped until execute reports the instruction
    assign squash = (state == st_wait_ex_ibar) || (state == st_wait_ex_csr) ||
                    (state == st_wait_ex_tlb);

endmodule

// ==== rtl/fetch_credit_counter.sv ====
`timescale 1ns/1ps

module fetch_credit_counter import fetch_pkg::*; (
    input  logic clk,
    input  logic rstn,
    input  logic flush,
    input  logic squash,
    input  logic fetch_req,
    input  logic rsp_take,
    input  logic skid_empty,
    input  logic fsm_idle,
    input  logic fifo_allowin,
    output logic if1_allowin
);

    // requests issued and not yet answered
    logic [CREDIT_W-1:0] count;
    logic                credit_ok;

    always_ff @(posedge clk) begin
        if (!rstn || flush || squash) begin
            // outstanding replies are dropped by the cache on these
            count <= '0;
        end else if (fetch_req && !rsp_take) begin
            count <= count + 1'b1;
        end else if (rsp_take && !fetch_req && count != '0) begin
            count <= count - 1'b1;
        end
    end

    assign credit_ok = (count < CREDIT_W'(FETCH_DEPTH));

    // every condition must hold for a new request to go out
    assign if1_allowin = credit_ok && skid_empty && fsm_idle && fifo_allowin;

endmodule

// ==== rtl/fetch_bundle_stage.sv ====
`timescale 1ns/1ps

module fetch_bundle_stage import fetch_pkg::*; (
    input  logic          clk,
    input  logic          rstn,
    input  logic          flush,
    input  logic          icache_rvalid,
    input  logic          fsm_idle,
    input  logic          fifo_allowin,
    input  fetch_bundle_t rsp,
    input  logic [1:0]    priv,
    output logic          rsp_take,
    output logic          skid_empty,
    output logic          out_valid,
    output fetch_bundle_t out
);

    fetch_bundle_t rsp_masked;
    fetch_bundle_t skid;
    logic          skid_valid;
    logic          slot_free;
    logic          skid_load;

    // responses during serialization or flush are thrown away
    assign rsp_take = icache_rvalid && fsm_idle && !flush;

    // output slot empty or being read this cycle
    assign slot_free = !out_valid || fifo_allowin;

    // new bundle parks in the skid when the slot cannot take it directly
    assign skid_load = rsp_take && (!slot_free || skid_valid);

    assign skid_empty = !skid_valid;

    always_comb begin
        rsp_masked = rsp;
        // fetch started at the upper word, slot 0 is not part of the stream
        if (rsp.pc[2]) begin
            rsp_masked.inst0 = INST_NOP;
        end
        // slot 1 sits behind a serializing instruction in slot 0
        if (priv[0]) begin
            rsp_masked.inst1     = INST_NOP;
            rsp_masked.excp_flag = 2'b00;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn || flush) begin
            out_valid  <= 1'b0;
            skid_valid <= 1'b0;
        end else if (slot_free) begin
            // skid moves up first, so the older bundle leaves first
            out_valid  <= skid_valid || rsp_take;
            skid_valid <= skid_valid && rsp_take;
        end else if (rsp_take) begin
            skid_valid <= 1'b1;
        end
    end

    // output slot payload
    always_ff @(posedge clk) begin
        if (slot_free) begin
            if (skid_valid) begin
                out <= skid;
            end else if (rsp_take) begin
                out <= rsp_masked;
            end
        end
    end

    // skid payload, already masked
    always_ff @(posedge clk) begin
        if (skid_load) begin
            skid <= rsp_masked;
        end
    end

endmodule

// ==== rtl/fetch_stage1.sv ====
`timescale 1ns/1ps

module fetch_stage1 import fetch_pkg::*; (
    input  logic          clk,
    input  logic          rstn,
    input  logic          flush,

    // first fetch stage
    input  logic          fetch_req,
    output logic          if1_allowin,

    // icache response with predecoder flags
    input  logic          icache_rvalid,
    input  fetch_bundle_t rsp,
    input  serial_flags_t rsp_flags,

    // instruction queue
    input  logic          fifo_allowin,
    output logic          out_valid,
    output fetch_bundle_t out,

    // back end reports
    input  serial_ack_t   ack,

    // serialization
    output logic          squash,
    output logic          redirect_valid,
    output logic [31:0]   redirect_pc
);

    logic rsp_take;
    logic skid_empty;
    logic fsm_idle;

    // stage register, skid and masking
    fetch_bundle_stage u_stage (
        .clk           (clk),
        .rstn          (rstn),
        .flush         (flush),
        .icache_rvalid (icache_rvalid),
        .fsm_idle      (fsm_idle),
        .fifo_allowin  (fifo_allowin),
        .rsp           (rsp),
        .priv          (rsp_flags.priv),
        .rsp_take      (rsp_take),
        .skid_empty    (skid_empty),
        .out_valid     (out_valid),
        .out           (out)
    );

    // ibar, csr write and tlb maintenance handling
    serial_fsm u_fsm (
        .clk            (clk),
        .rstn           (rstn),
        .flush          (flush),
        .rsp_take       (rsp_take),
        .rsp_flags      (rsp_flags),
        .rsp_pc         (rsp.pc),
        .rsp_pc_next    (rsp.pc_next),
        .ack            (ack),
        .fsm_idle       (fsm_idle),
        .squash         (squash),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    // upstream flow control
    fetch_credit_counter u_credit (
        .clk          (clk),
        .rstn         (rstn),
        .flush        (flush),
        .squash       (squash),
        .fetch_req    (fetch_req),
        .rsp_take     (rsp_take),
        .skid_empty   (skid_empty),
        .fsm_idle     (fsm_idle),
        .fifo_allowin (fifo_allowin),
        .if1_allowin  (if1_allowin)
    );

endmodule

// ==== sim/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic rstn
);

    // 20 ns period
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // reset held over four rising edges, released on a falling edge
    initial begin
        rstn = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
    end

endmodule

// ==== sim/fetch_stage1_tb.sv ====
`timescale 1ns/1ps

module fetch_stage1_tb import fetch_pkg::*; ();

    localparam int NUM_TESTS       = 6;
    localparam int CYCLES_PER_TEST = 600;
    localparam int TIMEOUT         = NUM_TESTS * CYCLES_PER_TEST;

    logic          clk;
    logic          rstn;
    logic          flush;
    logic          fetch_req;
    logic          if1_allowin;
    logic          icache_rvalid;
    fetch_bundle_t rsp;
    serial_flags_t rsp_flags;
    logic          fifo_allowin;
    logic          out_valid;
    fetch_bundle_t out_bundle;
    serial_ack_t   ack;
    logic          squash;
    logic          redirect_valid;
    logic [31:0]   redirect_pc;

    integer        seed = 83;
    int            cyc;
    int            err_count;
    int            check_count;
    int            tests_run;
    int            issued;
    int            delivered;
    int            sent;
    string         test_name;
    // bundles taken by the stage and not yet read by the queue
    fetch_bundle_t exp_q[$];
    // earliest cycle for each outstanding cache reply, oldest first
    int            due_q[$];
    int            req_left;
    logic          cache_stall;
    // queue model: 0 always ready, 1 random, 2 held off
    int            bp_mode;
    serial_flags_t flags_next;
    logic [31:0]   flag_pc;
    logic [31:0]   flag_pc_next;

    tb_clock clock_gen (
        .clk  (clk),
        .rstn (rstn)
    );

    fetch_stage1 dut (
        .clk            (clk),
        .rstn           (rstn),
        .flush          (flush),
        .fetch_req      (fetch_req),
        .if1_allowin    (if1_allowin),
        .icache_rvalid  (icache_rvalid),
        .rsp            (rsp),
        .rsp_flags      (rsp_flags),
        .fifo_allowin   (fifo_allowin),
        .out_valid      (out_valid),
        .out            (out_bundle),
        .ack            (ack),
        .squash         (squash),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    // what the queue should see for one cache response
    function automatic fetch_bundle_t ref_mask(input fetch_bundle_t b, input logic [1:0] priv);
        fetch_bundle_t m;
        m = b;
        if (b.pc[2]) begin
            m.inst0 = INST_NOP;
        end
        if (priv[0]) begin
            m.inst1     = INST_NOP;
            m.excp_flag = 2'b00;
        end
        return m;
    endfunction

    function automatic logic [31:0] restart_of(input logic [1:0] priv, input logic [31:0] pc,
                                               input logic [31:0] pc_next);
        logic [31:0] r;
        if (priv[0]) begin
            r = pc + 32'd4;
        end else if (priv[1]) begin
            r = pc + 32'd8;
        end else begin
            r = pc_next;
        end
        return r;
    endfunction

    // queue, cache and first stage models, all on the falling edge
    task automatic drive_models();
        logic [31:0]   r;
        fetch_bundle_t b;
        serial_flags_t f;
        r = $random(seed);
        if (bp_mode == 2) begin
            fifo_allowin = 1'b0;
        end else if (bp_mode == 1 && exp_q.size() + due_q.size() <= 2) begin
            // queue stalls only while all replies in flight fit in slot and skid
            fifo_allowin = r[0];
        end else begin
            fifo_allowin = 1'b1;
        end
        icache_rvalid = 1'b0;
        if (squash) begin
            due_q.delete();
        end else if (!cache_stall && due_q.size() > 0 && due_q[0] <= cyc) begin
            due_q.delete(0);
            r = $random(seed);
            b.pc = {r[31:2], 2'b00};
            b.pc_next = {b.pc[31:3] + 29'd1, 3'b000};
            b.inst0 = $random(seed);
            b.inst1 = $random(seed);
            b.badv = $random(seed);
            r = $random(seed);
            b.exception = r[6:0];
            b.excp_flag = r[9:8];
            b.cookie = sent;
            sent++;
            f = '0;
            f.priv = r[17:16];
            if (flags_next != '0) begin
                f = flags_next;
                flags_next = '0;
                flag_pc = b.pc;
                flag_pc_next = b.pc_next;
            end
            rsp = b;
            rsp_flags = f;
            icache_rvalid = 1'b1;
        end
        // if1_allowin depends on the queue level just driven
        #1;
        fetch_req = 1'b0;
        if (req_left > 0 && if1_allowin && !flush) begin
            fetch_req = 1'b1;
            req_left--;
        end
    endtask

    task automatic step();
        @(negedge clk);
        drive_models();
    endtask

    task automatic drain();
        while (due_q.size() > 0 || exp_q.size() > 0 || icache_rvalid) begin
            step();
        end
    endtask

    task automatic end_test(input int e0);
        tests_run++;
        if (err_count == e0) begin
            $display("test %s: passed", test_name);
        end else begin
            $display("test %s: %0d failures", test_name, err_count - e0);
        end
    endtask

    task automatic run_stream(input int n, input int mode);
        int d0;
        d0 = delivered;
        bp_mode = mode;
        req_left = n;
        while (req_left > 0) begin
            step();
        end
        drain();
        check_count++;
        if (delivered - d0 != n) begin
            $display("Fail %s: expected %0d bundles actual %0d", test_name, n, delivered - d0);
            err_count++;
        end
    endtask

    // path 0 ibar, 1 csr, 2 tlb
    task automatic run_serial(input string name, input serial_flags_t f, input int path);
        int          e0;
        int          d0;
        logic [31:0] exp_pc;
        test_name = name;
        e0 = err_count;
        d0 = delivered;
        bp_mode = 0;
        ack = '0;
        flags_next = f;
        req_left = 1;
        while (!squash) begin
            step();
        end
        exp_pc = restart_of(f.priv, flag_pc, flag_pc_next);
        check_count++;
        if (!redirect_valid) begin
            $display("%s: redirect_valid low while squash is high", test_name);
            err_count++;
        end
        if (redirect_pc !== exp_pc) begin
            $display("Fail %s: expected %h actual %h", test_name, exp_pc, redirect_pc);
            err_count++;
        end
        // execute has not reported the instruction yet
        repeat (4) begin
            step();
            if (!squash) begin
                $display("%s: squash fell before the execute report", test_name);
                err_count++;
            end
        end
        if (delivered - d0 != 1) begin
            $display("Fail %s: expected 1 bundle actual %0d", test_name, delivered - d0);
            err_count++;
        end
        case (path)
            0: ack.ibar_from_ex = 1'b1;
            1: ack.csr_from_ex = 1'b1;
            default: ack.tlb_from_ex = 1'b1;
        endcase
        step();
        ack = '0;
        if (squash || !redirect_valid) begin
            $display("%s: wrong squash or redirect_valid after the execute report", test_name);
            err_count++;
        end
        // a completion that belongs to another path
        case (path)
            0: ack.icache_idle = 1'b1;
            1: ack.tlb_done = 1'b1;
            default: ack.csr_done = 1'b1;
        endcase
        repeat (4) begin
            step();
            if (!redirect_valid) begin
                $display("%s: redirect_valid fell before its completion", test_name);
                err_count++;
            end
        end
        case (path)
            0: ack.dcache_idle = 1'b1;
            1: ack.csr_done = 1'b1;
            default: ack.tlb_done = 1'b1;
        endcase
        step();
        ack = '0;
        if (redirect_valid) begin
            $display("%s: redirect_valid still high after its completion", test_name);
            err_count++;
        end
        end_test(e0);
    endtask

    // compare process, sampled on the rising edge
    always @(posedge clk) begin : compare_proc
        fetch_bundle_t exp_b;
        cyc++;
        if (cyc >= TIMEOUT) begin
            $display("timeout after %0d cycles during %s", cyc, test_name);
            $display("Errors found");
            $finish;
        end else if (rstn) begin
            if (if1_allowin && exp_q.size() >= 2) begin
                $display("%s: if1_allowin high with a bundle in the skid buffer", test_name);
                err_count++;
            end
            if (out_valid && fifo_allowin) begin
                check_count++;
                if (exp_q.size() == 0) begin
                    $display("%s: bundle %h left the stage unexpected", test_name, out_bundle);
                    err_count++;
                end else begin
                    exp_b = exp_q.pop_front();
                    delivered++;
                    if (out_bundle !== exp_b) begin
                        $display("Fail %s: expected %h actual %h", test_name, exp_b, out_bundle);
                        err_count++;
                    end
                end
            end
            if (icache_rvalid && !redirect_valid && !flush) begin
                exp_q.push_back(ref_mask(rsp, rsp_flags.priv));
            end
            if (fetch_req) begin
                issued++;
                // reply 1 to 4 cycles after the request
                due_q.push_back(cyc + ($random(seed) & 3));
            end
            if (flush || squash) begin
                due_q.delete();
            end
            if (flush) begin
                exp_q.delete();
            end
        end
    end

    initial begin : stimulus
        serial_flags_t f;
        int            e0;
        int            i0;
        flush         = 1'b0;
        fetch_req     = 1'b0;
        icache_rvalid = 1'b0;
        rsp           = '0;
        rsp_flags     = '0;
        fifo_allowin  = 1'b1;
        ack           = '0;
        req_left      = 0;
        cache_stall   = 1'b0;
        bp_mode       = 0;
        flags_next    = '0;
        flag_pc       = '0;
        flag_pc_next  = '0;
        wait (rstn);
        step();

        test_name = "pass_through";
        e0 = err_count;
        check_count++;
        if (out_valid || squash || redirect_valid || (if1_allowin !== fifo_allowin)) begin
            $display("%s: outputs not at their reset values", test_name);
            err_count++;
        end
        run_stream(100, 0);
        end_test(e0);

        test_name = "back_pressure";
        e0 = err_count;
        run_stream(100, 1);
        end_test(e0);

        test_name = "credit_limit";
        e0 = err_count;
        i0 = issued;
        bp_mode = 0;
        cache_stall = 1'b1;
        req_left = 10;
        repeat (20) step();
        check_count++;
        if (issued - i0 != FETCH_DEPTH) begin
            $display("Fail %s: expected %0d requests actual %0d", test_name, FETCH_DEPTH,
                     issued - i0);
            err_count++;
        end
        if (if1_allowin) begin
            $display("%s: if1_allowin high with every credit in use", test_name);
            err_count++;
        end
        req_left = 0;
        // exactly one reply gets through
        cache_stall = 1'b0;
        step();
        cache_stall = 1'b1;
        step();
        if (!if1_allowin) begin
            $display("%s: if1_allowin stayed low after a response was taken", test_name);
            err_count++;
        end
        cache_stall = 1'b0;
        drain();
        end_test(e0);

        f = '{ibar: 2'b01, csr: 2'b00, tlb: 2'b00, priv: 2'b01};
        run_serial("barrier", f, 0);
        f = '{ibar: 2'b00, csr: 2'b10, tlb: 2'b10, priv: 2'b10};
        run_serial("csr_over_tlb", f, 1);
        f = '{ibar: 2'b00, csr: 2'b00, tlb: 2'b01, priv: 2'b00};
        run_serial("tlb_only", f, 2);

        test_name = "flush";
        e0 = err_count;
        // two bundles parked in slot and skid
        bp_mode = 0;
        cache_stall = 1'b1;
        req_left = 2;
        while (req_left > 0) begin
            step();
        end
        step();
        bp_mode = 2;
        cache_stall = 1'b0;
        while (exp_q.size() < 2) begin
            step();
        end
        check_count++;
        if (!out_valid) begin
            $display("%s: out_valid low with two bundles held under back-pressure", test_name);
            err_count++;
        end
        flush = 1'b1;
        step();
        flush = 1'b0;
        if (out_valid) begin
            $display("%s: out_valid still high after flush", test_name);
            err_count++;
        end
        // flush while waiting for execute
        bp_mode = 0;
        flags_next = '{ibar: 2'b01, csr: 2'b00, tlb: 2'b00, priv: 2'b00};
        req_left = 1;
        while (!squash) begin
            step();
        end
        flush = 1'b1;
        step();
        flush = 1'b0;
        if (redirect_valid || squash) begin
            $display("%s: serialization still active after flush", test_name);
            err_count++;
        end
        run_stream(20, 1);
        end_test(e0);

        $display("tests %0d, checks %0d, failures %0d", tests_run, check_count, err_count);
        if (err_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
rtl/fetch_pkg.sv
rtl/serial_fsm.sv
rtl/fetch_credit_counter.sv
rtl/fetch_bundle_stage.sv
rtl/fetch_stage1.sv
sim/tb_clock.sv
sim/fetch_stage1_tb.sv

// ==== Makefile ====
TOP = fetch_stage1_tb

.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f filelist.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -qx "No errors"

clean:
	rm -rf obj_dir
